// File: rtl/wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

  // ******************************
  // wishbone widths
  // ******************************
  localparam int WB_ADR_W    = 37;                // word address.
  localparam int WB_DAT_SIZE = 3;                 // log2 of data bytes.
  localparam int WB_DAT_W    = 8 << WB_DAT_SIZE;  // 64 bit data.
  localparam int WB_SEL_W    = WB_DAT_W / 8;      // one select per byte.

  typedef struct packed {
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
    logic                we;
  } wb_req_t;

  // bridge state machine.
  typedef enum logic [2:0] {
    BR_IDLE,
    BR_WRITE,
    BR_WRITE_RESP,
    BR_READ,
    BR_READ_DATA,
    BR_RECOVER
  } bridge_state_e;

endpackage

`default_nettype wire

// File: rtl/axi4l_pkg.sv
`default_nettype none

package axi4l_pkg;

  // ******************************
  // axi4-lite channel widths
  // ******************************
  localparam int AXI_ADDR_W     = 40;              // wishbone word address plus 3.
  localparam int AXI_DATA_W     = 64;
  localparam int AXI_STRB_W     = AXI_DATA_W / 8;
  localparam int AXI_BYTE_OFF_W = 3;               // byte offset within a word.

  typedef logic [AXI_ADDR_W-1:0] axi4l_addr_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi4l_w_t;

  // ******************************
  // memory model
  // ******************************
  localparam int MEM_ADDR_W = 8;
  localparam int MEM_WORDS  = 1 << MEM_ADDR_W;     // 256 words.

  typedef logic [MEM_ADDR_W-1:0] mem_index_t;

  localparam int ACCESS_DELAY = 20;                // wait cycles per access.
  localparam int DELAY_CNT_W  = $clog2(ACCESS_DELAY + 1);

  typedef enum logic [2:0] {
    MS_IDLE,
    MS_WRITE_WAIT,
    MS_READ_WAIT,
    MS_WRITE_RESP,
    MS_READ_RESP
  } mem_state_e;

endpackage

`default_nettype wire

// File: rtl/access_delay_timer.sv
`timescale 1ns/10ps
`default_nettype none

module access_delay_timer (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic start_i,
  output logic      done_o
);
  import axi4l_pkg::*;

  logic [DELAY_CNT_W-1:0] cnt_q;

  // ******************************
  // countdown
  // ******************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= DELAY_CNT_W'(ACCESS_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // last cycle before the count runs out.
  assign done_o = (cnt_q == DELAY_CNT_W'(1));

endmodule

`default_nettype wire

// File: rtl/mem_array.sv
`timescale 1ns/10ps
`default_nettype none

module mem_array (
  input  wire logic                        clk_i,
  input  wire logic                        we_i,
  input  wire logic                        re_i,
  input  wire axi4l_pkg::mem_index_t       idx_i,
  input  wire axi4l_pkg::axi4l_w_t         w_i,
  output logic [axi4l_pkg::AXI_DATA_W-1:0] rdata_o
);
  import axi4l_pkg::*;

  logic [AXI_DATA_W-1:0] mem_q [MEM_WORDS];

  // ******************************
  // byte strobed write
  // ******************************
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (w_i.strb[b]) begin
          mem_q[idx_i][8*b +: 8] <= w_i.data[8*b +: 8];
        end
      end
    end
  end

  // read word lands in the output register.
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi4l_mem_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module axi4l_mem_fsm (
  input  wire logic                             clk_i,
  input  wire logic                             rst_i,
  // axi4-lite slave
  input  wire logic                             awvalid_i,
  input  wire axi4l_pkg::axi4l_addr_t           aw_addr_i,
  input  wire logic                             wvalid_i,
  input  wire axi4l_pkg::axi4l_w_t              w_i,
  output logic                                  awready_o,
  output logic                                  wready_o,
  output logic                                  bvalid_o,
  input  wire logic                             bready_i,
  input  wire logic                             arvalid_i,
  input  wire axi4l_pkg::axi4l_addr_t           ar_addr_i,
  output logic                                  arready_o,
  output logic                                  rvalid_o,
  output logic [axi4l_pkg::AXI_DATA_W-1:0]      rdata_o,
  input  wire logic                             rready_i,
  // timer
  output logic                                  delay_start_o,
  input  wire logic                             delay_done_i,
  // memory
  output logic                                  mem_we_o,
  output logic                                  mem_re_o,
  output axi4l_pkg::mem_index_t                 mem_idx_o,
  output axi4l_pkg::axi4l_w_t                   mem_w_o,
  input  wire logic [axi4l_pkg::AXI_DATA_W-1:0] mem_rdata_i
);
  import axi4l_pkg::*;

  mem_state_e state_q;
  mem_state_e state_d;
  mem_index_t idx_q;
  axi4l_w_t   w_q;
  logic       aw_hs;
  logic       ar_hs;

  // address and data are taken in the same beat.
  assign awready_o = (state_q == MS_IDLE) && awvalid_i && wvalid_i;
  assign wready_o  = awready_o;
  assign arready_o = (state_q == MS_IDLE) && arvalid_i && !awready_o;  // write first.

  assign aw_hs = awvalid_i && awready_o;
  assign ar_hs = arvalid_i && arready_o;

  assign delay_start_o = aw_hs || ar_hs;

  always_comb begin
    state_d = state_q;
    case (state_q)
      MS_IDLE: begin
        if (aw_hs) begin
          state_d = MS_WRITE_WAIT;
        end else if (ar_hs) begin
          state_d = MS_READ_WAIT;
        end
      end
      MS_WRITE_WAIT: begin
        if (delay_done_i) begin
          state_d = MS_WRITE_RESP;
        end
      end
      MS_READ_WAIT: begin
        if (delay_done_i) begin
          state_d = MS_READ_RESP;
        end
      end
      MS_WRITE_RESP: begin
        if (bready_i) begin
          state_d = MS_IDLE;
        end
      end
      MS_READ_RESP: begin
        if (rready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // word index sits just above the byte offset.
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      idx_q <= aw_addr_i[AXI_BYTE_OFF_W +: MEM_ADDR_W];
      w_q   <= w_i;
    end else if (ar_hs) begin
      idx_q <= ar_addr_i[AXI_BYTE_OFF_W +: MEM_ADDR_W];
    end
  end

  assign mem_we_o  = (state_q == MS_WRITE_WAIT) && delay_done_i;
  assign mem_re_o  = (state_q == MS_READ_WAIT) && delay_done_i;
  assign mem_idx_o = idx_q;
  assign mem_w_o   = w_q;

  assign bvalid_o = (state_q == MS_WRITE_RESP);
  assign rvalid_o = (state_q == MS_READ_RESP);
  assign rdata_o  = mem_rdata_i;  // registered in the array.

endmodule

`default_nettype wire

// File: rtl/wb_to_axi4l.sv
`timescale 1ns/10ps
`default_nettype none

module wb_to_axi4l (
  input  wire logic                             clk_i,
  input  wire logic                             rst_i,
  // wishbone classic slave
  input  wire wb_bus_pkg::wb_req_t              wb_req_i,
  input  wire logic                             wb_stb_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]       wb_dat_o,
  output logic                                  wb_ack_o,
  // axi4-lite master
  output logic                                  awvalid_o,
  output axi4l_pkg::axi4l_addr_t                aw_addr_o,
  output logic                                  wvalid_o,
  output axi4l_pkg::axi4l_w_t                   w_o,
  input  wire logic                             awready_i,
  input  wire logic                             wready_i,
  input  wire logic                             bvalid_i,
  output logic                                  bready_o,
  output logic                                  arvalid_o,
  output axi4l_pkg::axi4l_addr_t                ar_addr_o,
  input  wire logic                             arready_i,
  input  wire logic                             rvalid_i,
  input  wire logic [axi4l_pkg::AXI_DATA_W-1:0] rdata_i,
  output logic                                  rready_o
);
  import wb_bus_pkg::*;
  import axi4l_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  wb_req_t       req_q;
  logic          aw_done_q;
  logic          w_done_q;
  logic          aw_hs;
  logic          w_hs;
  logic          aw_fin;
  logic          w_fin;

  assign aw_hs  = awvalid_o && awready_i;
  assign w_hs   = wvalid_o && wready_i;
  assign aw_fin = aw_done_q || aw_hs;  // address beat gone.
  assign w_fin  = w_done_q || w_hs;    // data beat gone.

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: begin
        if (wb_stb_i) begin
          state_d = wb_req_i.we ? BR_WRITE : BR_READ;
        end
      end
      BR_WRITE: begin
        if (aw_fin && w_fin) begin
          state_d = BR_WRITE_RESP;
        end
      end
      BR_WRITE_RESP: begin
        if (bvalid_i) begin
          state_d = BR_RECOVER;
        end
      end
      BR_READ: begin
        if (arvalid_o && arready_i) begin
          state_d = BR_READ_DATA;
        end
      end
      BR_READ_DATA: begin
        if (rvalid_i) begin
          state_d = BR_RECOVER;
        end
      end
      BR_RECOVER: state_d = BR_IDLE;  // strobe ignored here.
      default:    state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= BR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= (state_d == BR_WRITE) && aw_fin;
      w_done_q  <= (state_d == BR_WRITE) && w_fin;
    end
  end

  // request is captured once per access.
  always_ff @(posedge clk_i) begin
    if (state_q == BR_IDLE && wb_stb_i) begin
      req_q <= wb_req_i;
    end
  end

  assign aw_addr_o = {req_q.adr, {WB_DAT_SIZE{1'b0}}};
  assign ar_addr_o = {req_q.adr, {WB_DAT_SIZE{1'b0}}};
  assign w_o       = axi4l_w_t'{data: req_q.dat, strb: req_q.sel};

  assign awvalid_o = (state_q == BR_WRITE) && !aw_done_q;
  assign wvalid_o  = (state_q == BR_WRITE) && !w_done_q;
  assign arvalid_o = (state_q == BR_READ);
  assign bready_o  = (state_q == BR_WRITE_RESP);
  assign rready_o  = (state_q == BR_READ_DATA);

  assign wb_ack_o = (bvalid_i && bready_o) || (rvalid_i && rready_o);
  assign wb_dat_o = rdata_i;  // valid with the read ack.

endmodule

`default_nettype wire

// File: rtl/wb_axi4l_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_axi4l_mem_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire wb_bus_pkg::wb_req_t        wb_req_i,
  input  wire logic                       wb_stb_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic                            wb_ack_o
);
  import wb_bus_pkg::*;
  import axi4l_pkg::*;

  // ******************************
  // axi4-lite link
  // ******************************
  logic                  awvalid;
  axi4l_addr_t           aw_addr;
  logic                  wvalid;
  axi4l_w_t              w;
  logic                  awready;
  logic                  wready;
  logic                  bvalid;
  logic                  bready;
  logic                  arvalid;
  axi4l_addr_t           ar_addr;
  logic                  arready;
  logic                  rvalid;
  logic [AXI_DATA_W-1:0] rdata;
  logic                  rready;

  // slave side.
  logic                  delay_start;
  logic                  delay_done;
  logic                  mem_we;
  logic                  mem_re;
  mem_index_t            mem_idx;
  axi4l_w_t              mem_w;
  logic [AXI_DATA_W-1:0] mem_rdata;

  wb_to_axi4l wb_to_axi4l_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_req_i  (wb_req_i),
    .wb_stb_i  (wb_stb_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .awvalid_o (awvalid),
    .aw_addr_o (aw_addr),
    .wvalid_o  (wvalid),
    .w_o       (w),
    .awready_i (awready),
    .wready_i  (wready),
    .bvalid_i  (bvalid),
    .bready_o  (bready),
    .arvalid_o (arvalid),
    .ar_addr_o (ar_addr),
    .arready_i (arready),
    .rvalid_i  (rvalid),
    .rdata_i   (rdata),
    .rready_o  (rready)
  );

  axi4l_mem_fsm axi4l_mem_fsm_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .awvalid_i     (awvalid),
    .aw_addr_i     (aw_addr),
    .wvalid_i      (wvalid),
    .w_i           (w),
    .awready_o     (awready),
    .wready_o      (wready),
    .bvalid_o      (bvalid),
    .bready_i      (bready),
    .arvalid_i     (arvalid),
    .ar_addr_i     (ar_addr),
    .arready_o     (arready),
    .rvalid_o      (rvalid),
    .rdata_o       (rdata),
    .rready_i      (rready),
    .delay_start_o (delay_start),
    .delay_done_i  (delay_done),
    .mem_we_o      (mem_we),
    .mem_re_o      (mem_re),
    .mem_idx_o     (mem_idx),
    .mem_w_o       (mem_w),
    .mem_rdata_i   (mem_rdata)
  );

  access_delay_timer access_delay_timer_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (delay_start),
    .done_o  (delay_done)
  );

  mem_array mem_array_inst (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .re_i    (mem_re),
    .idx_i   (mem_idx),
    .w_i     (mem_w),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: bench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each row holds we, word address, data, select and expected read data.
// expected read data is only checked on reads.
localparam logic OP_WR = 1'b1;
localparam logic OP_RD = 1'b0;

typedef struct packed {
  logic                we;
  logic [WB_ADR_W-1:0] adr;
  logic [WB_DAT_W-1:0] dat;
  logic [WB_SEL_W-1:0] sel;
  logic [WB_DAT_W-1:0] exp_rdata;
} vector_t;

localparam int NUM_VECTORS = 14;

vector_t vectors [NUM_VECTORS];

task automatic fill_vectors();
  // full word write, then read back.
  vectors[0]  = '{OP_WR, 37'h00_0000_0010, 64'h0123_4567_89ab_cdef, 8'hff, 64'h0};
  vectors[1]  = '{OP_RD, 37'h00_0000_0010, 64'h0, 8'h00, 64'h0123_4567_89ab_cdef};
  // partial selects keep the other bytes.
  vectors[2]  = '{OP_WR, 37'h00_0000_0010, 64'hffff_ffff_a5a5_a5a5, 8'h0f, 64'h0};
  vectors[3]  = '{OP_RD, 37'h00_0000_0010, 64'h0, 8'h00, 64'h0123_4567_a5a5_a5a5};
  vectors[4]  = '{OP_WR, 37'h00_0000_0010, 64'h5a00_0000_0000_00c3, 8'h81, 64'h0};
  vectors[5]  = '{OP_RD, 37'h00_0000_0010, 64'h0, 8'h00, 64'h5a23_4567_a5a5_a5c3};
  // high word address bits alias.
  vectors[6]  = '{OP_WR, 37'h01_0000_0042, 64'hdead_beef_cafe_f00d, 8'hff, 64'h0};
  vectors[7]  = '{OP_RD, 37'h00_0000_0042, 64'h0, 8'h00, 64'hdead_beef_cafe_f00d};
  vectors[8]  = '{OP_WR, 37'h00_0000_00a5, 64'h1111_2222_3333_4444, 8'hff, 64'h0};
  vectors[9]  = '{OP_RD, 37'h1f_ffff_ffa5, 64'h0, 8'h00, 64'h1111_2222_3333_4444};
  // alias plus partial select on word 0.
  vectors[10] = '{OP_WR, 37'h00_0000_0200, 64'h8877_6655_4433_2211, 8'hff, 64'h0};
  vectors[11] = '{OP_RD, 37'h00_0000_0000, 64'h0, 8'h00, 64'h8877_6655_4433_2211};
  vectors[12] = '{OP_WR, 37'h00_0000_0300, 64'h0000_aabb_ccdd_0000, 8'h3c, 64'h0};
  vectors[13] = '{OP_RD, 37'h01_2345_6700, 64'h0, 8'h00, 64'h8877_aabb_ccdd_2211};
endtask

`endif

// File: bench/tb_wb_axi4l_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_axi4l_mem;
  import wb_bus_pkg::*;
  import axi4l_pkg::*;

  `include "tb_vectors.svh"

  localparam int NUM_RANDOM  = 40;
  localparam int ACK_EDGE    = ACCESS_DELAY + 2;  // edges from first strobe sample.
  localparam int ACK_WAIT    = 2 * ACK_EDGE;
  localparam int CYCLE_LIMIT = (NUM_VECTORS + NUM_RANDOM) * (ACCESS_DELAY + 4) + 50;

  logic                clk = 1'b0;  // no edge at time zero.
  logic                rst;
  wb_req_t             wb_req;
  logic                wb_stb;
  logic [WB_DAT_W-1:0] wb_dat;
  logic                wb_ack;

  logic [31:0]         rng_state;
  int                  cycle_cnt = 0;
  logic [WB_DAT_W-1:0] shadow [MEM_WORDS];
  logic                written [MEM_WORDS];
  mem_index_t          written_idx [$];

  wb_axi4l_mem_top wb_axi4l_mem_top_inst (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_req_i (wb_req),
    .wb_stb_i (wb_stb),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // ******************************
  // error handling
  // ******************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_mismatch(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
    abort_run($sformatf("[FAIL] time %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic void update_shadow(input mem_index_t idx, input logic [63:0] dat,
                                        input logic [7:0] sel);
    for (int b = 0; b < WB_SEL_W; b++) begin
      if (sel[b]) begin
        shadow[idx][8*b +: 8] = dat[8*b +: 8];
      end
    end
    if (!written[idx]) begin
      written[idx] = 1'b1;
      written_idx.push_back(idx);
    end
  endfunction

  // ack must stay low in reset and with no strobe.
  always @(negedge clk) begin
    if (rst || !wb_stb) begin
      assert (!wb_ack) else value_mismatch("wb_ack_o", 64'(0), 64'(wb_ack));
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: run went past %0d clock cycles", CYCLE_LIMIT));
    end
  end

  // ******************************
  // one wishbone access
  // ******************************
  task automatic run_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat, input logic [WB_SEL_W-1:0] sel,
                            output logic [WB_DAT_W-1:0] rdata);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    @(posedge clk);
    #1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    wb_req.we  = we;
    wb_stb     = 1'b1;
    // value at a negedge is what the next posedge samples.
    while (!seen && edges <= ACK_WAIT) begin
      @(negedge clk);
      if (wb_ack) begin
        seen = 1'b1;
      end else begin
        edges++;
        @(posedge clk);
      end
    end
    if (!seen) begin
      abort_run($sformatf("no acknowledge within %0d cycles of the strobe", ACK_WAIT));
    end else begin
      assert (edges == ACK_EDGE)
        else value_mismatch("wb_ack_o edge count", 64'(ACK_EDGE), 64'(edges));
      rdata = wb_dat;
      @(posedge clk);
      #1;
      wb_stb = 1'b0;
      @(negedge clk);
      assert (!wb_ack) else value_mismatch("wb_ack_o", 64'(0), 64'(wb_ack));  // one cycle.
    end
  endtask

  task automatic run_random_phase();
    logic [31:0]         r;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
    logic [WB_DAT_W-1:0] rdata;
    mem_index_t          idx;
    int                  pick;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      if (written_idx.size() == 0 || r[0]) begin
        idx = r[15:8];
        sel = written[idx] ? r[23:16] : {WB_SEL_W{1'b1}};  // first write fills the word.
        rng_state = xorshift32(rng_state);
        dat[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        dat[31:0] = rng_state;
        rng_state = xorshift32(rng_state);
        adr = {rng_state[WB_ADR_W-MEM_ADDR_W-1:0], idx};
        run_access(OP_WR, adr, dat, sel, rdata);
        update_shadow(idx, dat, sel);
      end else begin
        pick = int'(r[31:8]) % written_idx.size();
        idx = written_idx[pick];
        rng_state = xorshift32(rng_state);
        adr = {rng_state[WB_ADR_W-MEM_ADDR_W-1:0], idx};
        run_access(OP_RD, adr, '0, '0, rdata);
        assert (rdata == shadow[idx]) else value_mismatch("wb_dat_o", shadow[idx], rdata);
      end
    end
  endtask

  // ******************************
  // main sequence
  // ******************************
  initial begin
    logic [WB_DAT_W-1:0] rdata;
    rst       = 1'b1;
    wb_stb    = 1'b0;
    wb_req    = '0;
    rng_state = 32'h895c;
    fill_vectors();
    for (int i = 0; i < MEM_WORDS; i++) begin
      written[i] = 1'b0;
      shadow[i]  = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_access(vectors[i].we, vectors[i].adr, vectors[i].dat, vectors[i].sel, rdata);
      if (vectors[i].we == OP_RD) begin
        assert (rdata == vectors[i].exp_rdata)
          else value_mismatch("wb_dat_o", vectors[i].exp_rdata, rdata);
      end
    end

    run_random_phase();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
rtl/wb_bus_pkg.sv
rtl/axi4l_pkg.sv
rtl/access_delay_timer.sv
rtl/mem_array.sv
rtl/axi4l_mem_fsm.sv
rtl/wb_to_axi4l.sv
rtl/wb_axi4l_mem_top.sv
bench/tb_wb_axi4l_mem.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_wb_axi4l_mem -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
